// File: rtl/fp_accel_pkg.sv
package fp_accel_pkg;

    // Single-precision format
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int FP_W = 32;

    // Aligned mantissa: implicit bit, fraction, MAN_W guard bits
    localparam int ALIGN_W = 2 * MAN_W + 1;
    // One extra bit for the carry out of the magnitude add
    localparam int SUM_W = ALIGN_W + 1;
    localparam int POS_W = $clog2(SUM_W);

    localparam int PIPE_LATENCY = 7;

    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    // APB bus widths and register map
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;
    localparam logic [APB_AW-1:0] ADDR_OPA = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_OPB = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_CMD = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'hC;

    typedef struct packed {
        logic sign;
        logic [EXP_W-1:0] exp;
        logic [MAN_W-1:0] man;
    } fp_fields_t;

    typedef union packed {
        logic [FP_W-1:0] raw;
        fp_fields_t f;
    } fp_word_u;

    typedef struct packed {
        fp_word_u a;
        fp_word_u b;
        logic sub;
    } fp_op_t;

    typedef struct packed {
        fp_word_u value;
        logic underflow;
        logic overflow;
    } fp_result_t;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

endpackage

// File: rtl/leading_one_detector.sv
module leading_one_detector (
    input  logic [fp_accel_pkg::SUM_W-1:0] value,
    output logic [fp_accel_pkg::POS_W-1:0] position,
    output logic                           found
);
    import fp_accel_pkg::*;

    // Priority scan, the first set bit from the top wins
    always_comb begin
        position = '0;
        found = 1'b0;
        for (int i = SUM_W - 1; i >= 0; i--) begin
            if (!found && value[i]) begin
                position = POS_W'(i);
                found = 1'b1;
            end
        end
    end

endmodule

// File: rtl/result_rounder.sv
module result_rounder (
    input  logic signed [fp_accel_pkg::EXP_W+1:0] exp_in,
    input  logic [fp_accel_pkg::MAN_W-1:0]        man_in,
    input  logic [fp_accel_pkg::MAN_W-1:0]        round_bits,
    input  logic                                  sign,
    output fp_accel_pkg::fp_result_t              result
);
    import fp_accel_pkg::*;

    logic guard;
    logic rest;
    logic round_up;
    logic [MAN_W:0] man_rnd;
    logic signed [EXP_W+1:0] exp_rnd;

    assign guard = round_bits[MAN_W-1];
    assign rest = |round_bits[MAN_W-2:0];

    // Above half rounds up, exactly half rounds to the even mantissa
    assign round_up = guard && (rest || man_in[0]);
    assign man_rnd = {1'b0, man_in} + (MAN_W + 1)'(round_up);

    // Carry out of the fraction bumps the exponent, fraction wraps to zero
    assign exp_rnd = exp_in + $signed((EXP_W + 2)'(man_rnd[MAN_W]));

    always_comb begin
        result = '0;
        result.value.f.sign = sign;
        if (exp_rnd >= 2 ** EXP_W - 1) begin
            result.value.f.exp = '1;
            result.value.f.man = '0;
            result.overflow = 1'b1;
        end else if (exp_rnd <= 0) begin
            // Flush to signed zero
            result.value.f.exp = '0;
            result.value.f.man = '0;
            result.underflow = 1'b1;
        end else begin
            result.value.f.exp = exp_rnd[EXP_W-1:0];
            result.value.f.man = man_rnd[MAN_W-1:0];
        end
    end

endmodule

// File: rtl/fp_add_pipe.sv
module fp_add_pipe (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  fp_accel_pkg::fp_op_t     issue_op,
    output logic                     res_valid,
    output fp_accel_pkg::fp_result_t res_data
);
    import fp_accel_pkg::*;

    // vld[n] qualifies stage n
    logic [PIPE_LATENCY-1:0] vld;

    fp_op_t s0_op;

    fp_fields_t s1_a;
    fp_fields_t s1_b;

    logic [ALIGN_W-1:0] a_full;
    logic [ALIGN_W-1:0] b_full;
    logic [ALIGN_W-1:0] small_full;
    logic [ALIGN_W-1:0] small_shift;
    logic [EXP_W-1:0] exp_diff;
    logic a_larger;
    logic sticky;

    logic [ALIGN_W-1:0] s2_large_man;
    logic [ALIGN_W-1:0] s2_small_man;
    logic [EXP_W-1:0] s2_exp;
    logic s2_large_sign;
    logic s2_small_sign;

    logic [SUM_W-1:0] s3_sum;
    logic [EXP_W-1:0] s3_exp;
    logic s3_sign;

    logic [POS_W-1:0] lod_pos;
    logic lod_found;

    logic [SUM_W-1:0] s4_sum;
    logic [POS_W-1:0] s4_pos;
    logic s4_found;
    logic [EXP_W-1:0] s4_exp;
    logic s4_sign;

    logic [SUM_W-1:0] norm_sum;
    logic [POS_W-1:0] lshift;
    logic signed [EXP_W+1:0] exp_wide;
    logic signed [EXP_W+1:0] norm_exp;

    logic signed [EXP_W+1:0] s5_exp;
    logic [MAN_W-1:0] s5_man;
    logic [MAN_W-1:0] s5_round;
    logic s5_sign;
    logic s5_zero;

    fp_result_t rnd_res;
    fp_result_t s6_res;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld <= '0;
        end else begin
            vld <= {vld[PIPE_LATENCY-2:0], issue_valid};
        end
    end

    always_ff @(posedge clk) begin
        s0_op <= issue_op;
    end

    // Unpack, exponent-zero inputs become zero, subtract flips b
    always_ff @(posedge clk) begin
        s1_a.sign <= s0_op.a.f.sign;
        s1_a.exp <= s0_op.a.f.exp;
        s1_a.man <= (s0_op.a.f.exp == '0) ? '0 : s0_op.a.f.man;
        s1_b.sign <= s0_op.b.f.sign ^ s0_op.sub;
        s1_b.exp <= s0_op.b.f.exp;
        s1_b.man <= (s0_op.b.f.exp == '0) ? '0 : s0_op.b.f.man;
    end

    always_comb begin
        a_full = {(|s1_a.exp), s1_a.man, {MAN_W{1'b0}}};
        b_full = {(|s1_b.exp), s1_b.man, {MAN_W{1'b0}}};
        a_larger = (s1_a.exp >= s1_b.exp);
        exp_diff = a_larger ? (s1_a.exp - s1_b.exp) : (s1_b.exp - s1_a.exp);
        small_full = a_larger ? b_full : a_full;
        small_shift = small_full >> exp_diff;
        // Bits shifted past the guard field collapse into one sticky bit
        sticky = |(small_full & ~({ALIGN_W{1'b1}} << exp_diff));
    end

    always_ff @(posedge clk) begin
        s2_exp <= a_larger ? s1_a.exp : s1_b.exp;
        s2_large_man <= a_larger ? a_full : b_full;
        s2_small_man <= {small_shift[ALIGN_W-1:1], small_shift[0] | sticky};
        s2_large_sign <= a_larger ? s1_a.sign : s1_b.sign;
        s2_small_sign <= a_larger ? s1_b.sign : s1_a.sign;
    end

    always_ff @(posedge clk) begin
        s3_exp <= s2_exp;
        if (s2_large_sign == s2_small_sign) begin
            s3_sum <= {1'b0, s2_large_man} + {1'b0, s2_small_man};
            s3_sign <= s2_large_sign;
        end else if (s2_large_man >= s2_small_man) begin
            s3_sum <= {1'b0, s2_large_man} - {1'b0, s2_small_man};
            s3_sign <= s2_large_sign;
        end else begin
            s3_sum <= {1'b0, s2_small_man} - {1'b0, s2_large_man};
            s3_sign <= s2_small_sign;
        end
    end

    leading_one_detector u_lod (
        .value    (s3_sum),
        .position (lod_pos),
        .found    (lod_found)
    );

    always_ff @(posedge clk) begin
        s4_sum <= s3_sum;
        s4_pos <= lod_pos;
        s4_found <= lod_found;
        s4_exp <= s3_exp;
        s4_sign <= s3_sign;
    end

    // Leading one goes to bit SUM_W-2, the implicit bit position
    always_comb begin
        exp_wide = {2'b00, s4_exp};
        lshift = POS_W'(SUM_W - 2) - s4_pos;
        if (s4_pos == POS_W'(SUM_W - 1)) begin
            norm_sum = s4_sum >> 1;
            norm_sum[0] = norm_sum[0] | s4_sum[0];
            norm_exp = exp_wide + $signed((EXP_W + 2)'(1));
        end else begin
            norm_sum = s4_sum << lshift;
            norm_exp = exp_wide - $signed((EXP_W + 2)'(lshift));
        end
    end

    always_ff @(posedge clk) begin
        s5_exp <= norm_exp;
        s5_man <= norm_sum[SUM_W-3 -: MAN_W];
        s5_round <= norm_sum[MAN_W-1:0];
        s5_sign <= s4_sign;
        s5_zero <= !s4_found;
    end

    result_rounder u_rounder (
        .exp_in     (s5_exp),
        .man_in     (s5_man),
        .round_bits (s5_round),
        .sign       (s5_sign),
        .result     (rnd_res)
    );

    // Exact cancellation is positive zero without flags
    always_ff @(posedge clk) begin
        s6_res <= s5_zero ? '0 : rnd_res;
    end

    assign res_valid = vld[PIPE_LATENCY-1];
    assign res_data = s6_res;

    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        res_valid == $past(issue_valid, PIPE_LATENCY)
    );

endmodule

// File: rtl/apb_op_regs.sv
module apb_op_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  fp_accel_pkg::apb_req_t              apb_req,
    output fp_accel_pkg::apb_rsp_t              apb_rsp,
    output logic                                issue_valid,
    output fp_accel_pkg::fp_op_t                issue_op,
    input  logic                                res_valid,
    input  fp_accel_pkg::fp_result_t            res_data,
    input  logic                                pop,
    input  logic [fp_accel_pkg::CNT_W-1:0]      fifo_count
);
    import fp_accel_pkg::*;

    logic access;
    logic addr_ok;
    logic is_cmd;
    logic stall;
    logic wr_done;
    logic status_wr;
    logic credits_full;
    logic last_sub;
    logic sticky_unf;
    logic sticky_ovf;
    logic [CNT_W-1:0] credits;
    fp_word_u opa;
    fp_word_u opb;

    assign access = apb_req.psel && apb_req.penable;
    assign is_cmd = (apb_req.paddr == ADDR_CMD);
    assign credits_full = (credits == CNT_W'(FIFO_DEPTH));

    always_comb begin
        case (apb_req.paddr)
            ADDR_OPA, ADDR_OPB, ADDR_CMD, ADDR_STATUS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
    end

    // CMD write waits until the FIFO has a slot reserved for its result
    assign stall = access && apb_req.pwrite && is_cmd && credits_full;
    assign wr_done = access && apb_req.pwrite && addr_ok && !stall;
    assign status_wr = wr_done && (apb_req.paddr == ADDR_STATUS);
    assign issue_valid = wr_done && is_cmd;

    always_comb begin
        issue_op.a = opa;
        issue_op.b = opb;
        issue_op.sub = apb_req.pwdata[0];
    end

    always_comb begin
        apb_rsp.pready = !stall;
        apb_rsp.pslverr = access && !addr_ok;
        case (apb_req.paddr)
            ADDR_OPA: apb_rsp.prdata = opa.raw;
            ADDR_OPB: apb_rsp.prdata = opb.raw;
            ADDR_CMD: apb_rsp.prdata = {{(APB_DW - 1){1'b0}}, last_sub};
            ADDR_STATUS: begin
                apb_rsp.prdata = {{(APB_DW - 8){1'b0}}, fifo_count, 2'b00,
                                  sticky_ovf, sticky_unf};
            end
            default: apb_rsp.prdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opa.raw <= '0;
            opb.raw <= '0;
            last_sub <= 1'b0;
        end else if (wr_done) begin
            case (apb_req.paddr)
                ADDR_OPA: opa.raw <= apb_req.pwdata;
                ADDR_OPB: opb.raw <= apb_req.pwdata;
                ADDR_CMD: last_sub <= apb_req.pwdata[0];
                default: ;
            endcase
        end
    end

    // One credit per operation between issue and pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= '0;
        end else begin
            credits <= credits + CNT_W'(issue_valid) - CNT_W'(pop);
        end
    end

    // New flags win over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sticky_unf <= 1'b0;
            sticky_ovf <= 1'b0;
        end else begin
            sticky_unf <= (sticky_unf && !(status_wr && apb_req.pwdata[0]))
                          || (res_valid && res_data.underflow);
            sticky_ovf <= (sticky_ovf && !(status_wr && apb_req.pwdata[1]))
                          || (res_valid && res_data.overflow);
        end
    end

    // Every stored result still holds a credit, so a full FIFO means full credits
    a_no_issue_full: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> (fifo_count < CNT_W'(FIFO_DEPTH))
    );

    a_credit_bound: assert property (
        @(posedge clk) disable iff (rst)
        credits <= CNT_W'(FIFO_DEPTH)
    );

endmodule

// File: rtl/result_fifo.sv
module result_fifo (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_valid,
    input  fp_accel_pkg::fp_result_t       wr_data,
    output logic                           out_valid,
    output fp_accel_pkg::fp_result_t       out_data,
    input  logic                           out_ready,
    output logic                           pop,
    output logic [fp_accel_pkg::CNT_W-1:0] count
);
    import fp_accel_pkg::*;

    fp_result_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // Head entry comes straight from the storage registers
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_valid) - CNT_W'(pop);
        end
    end

    // The credit scheme upstream keeps a slot free for every result in flight
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        wr_valid |-> (count < CNT_W'(FIFO_DEPTH))
    );

    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

// File: rtl/fp_accel_top.sv
module fp_accel_top (
    input  logic                     clk,
    input  logic                     rst,
    input  fp_accel_pkg::apb_req_t   apb_req,
    output fp_accel_pkg::apb_rsp_t   apb_rsp,
    output logic                     out_valid,
    output fp_accel_pkg::fp_result_t out_data,
    input  logic                     out_ready
);
    import fp_accel_pkg::*;

    logic issue_valid;
    fp_op_t issue_op;
    logic res_valid;
    fp_result_t res_data;
    logic pop;
    logic [CNT_W-1:0] fifo_count;

    apb_op_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .pop         (pop),
        .fifo_count  (fifo_count)
    );

    fp_add_pipe u_pipe (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .res_valid   (res_valid),
        .res_data    (res_data)
    );

    result_fifo u_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_valid  (res_valid),
        .wr_data   (res_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .pop       (pop),
        .count     (fifo_count)
    );

endmodule

// File: tb/tb_fp_accel.sv
module tb_fp_accel;
    timeunit 1ns;
    timeprecision 100ps;
    import fp_accel_pkg::*;

    logic clk = 1'b0;
    logic rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic out_valid;
    fp_result_t out_data;
    logic out_ready;

    fp_result_t exp_q[$];
    fp_result_t exp_head;
    logic exp_avail;
    logic lat_en;
    logic cmd_done;
    int issued;
    int popped;
    int seed;
    string test_name;

    fp_accel_top u_dut (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic mismatch(input string what, input logic [63:0] want, input logic [63:0] got);
        $display("CHECK FAILED %s %s expected %h actual %h", test_name, what, want, got);
        abort_run();
    endtask

    task automatic give_up(input string what);
        $display("ERROR in %s: %s", test_name, what);
        abort_run();
    endtask

    function automatic void update_head();
        exp_avail = (exp_q.size() > 0);
        exp_head = exp_avail ? exp_q[0] : '0;
    endfunction

    // Behavioral model with 32 guard bits below the fraction and a sticky bit
    function automatic fp_result_t ref_add(input logic [31:0] a, input logic [31:0] b,
                                           input logic sub);
        fp_result_t r;
        logic sb;
        logic swap;
        logic sl;
        logic ss;
        int ea;
        int eb;
        int el;
        int d;
        int p;
        int e;
        logic [63:0] ma;
        logic [63:0] mb;
        logic [63:0] ml;
        logic [63:0] ms;
        logic [63:0] sum;
        logic [63:0] mant;
        logic [63:0] rem;
        logic [63:0] half;
        r = '0;
        sb = b[31] ^ sub;
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        ma = (ea == 0) ? 64'd0 : ((64'd1 << 55) | (64'(a[22:0]) << 32));
        mb = (eb == 0) ? 64'd0 : ((64'd1 << 55) | (64'(b[22:0]) << 32));
        swap = (eb > ea) || (eb == ea && mb > ma);
        ml = swap ? mb : ma;
        ms = swap ? ma : mb;
        el = swap ? eb : ea;
        d = swap ? eb - ea : ea - eb;
        sl = swap ? sb : a[31];
        ss = swap ? a[31] : sb;
        if (d > 60) begin
            ms = (ms != 0) ? 64'd1 : 64'd0;
        end else begin
            ms = (ms >> d) | 64'((ms & ((64'd1 << d) - 1)) != 0);
        end
        sum = (sl == ss) ? ml + ms : ml - ms;
        if (sum == 0) begin
            return r;
        end
        p = 63;
        while (!sum[p]) begin
            p--;
        end
        e = el + p - 55;
        mant = sum >> (p - 23);
        rem = sum & ((64'd1 << (p - 23)) - 1);
        half = 64'd1 << (p - 24);
        if (rem > half || (rem == half && mant[0])) begin
            mant = mant + 1;
        end
        if (mant[24]) begin
            mant = mant >> 1;
            e = e + 1;
        end
        r.value.f.sign = sl;
        if (e >= 255) begin
            r.value.f.exp = 8'hff;
            r.overflow = 1'b1;
        end else if (e <= 0) begin
            r.underflow = 1'b1;
        end else begin
            r.value.f.exp = 8'(e);
            r.value.f.man = mant[22:0];
        end
        return r;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
        int n;
        @(posedge clk);
        #1;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = wr;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        #1;
        n = 0;
        while (!apb_rsp.pready) begin
            @(posedge clk);
            #2;
            n++;
            if (n > 200) give_up("APB transfer never completed");
        end
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b1, addr, data, rd, err);
        assert (!err) else mismatch("pslverr on mapped write", 64'd0, 64'(err));
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] want,
                              input logic [31:0] mask, input string what);
        logic [31:0] rd;
        logic err;
        apb_xfer(1'b0, addr, '0, rd, err);
        assert (!err) else mismatch({what, " pslverr"}, 64'd0, 64'(err));
        assert ((rd & mask) == want) else mismatch(what, 64'(want), 64'(rd & mask));
    endtask

    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic sub);
        write_reg(ADDR_OPA, a);
        write_reg(ADDR_OPB, b);
        write_reg(ADDR_CMD, {31'd0, sub});
        exp_q.push_back(ref_add(a, b, sub));
        update_head();
        issued++;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (popped != issued) begin
            @(posedge clk);
            n++;
            if (n > 500) give_up("timeout waiting for results to drain");
        end
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            popped++;
            update_head();
        end
    end

    assign cmd_done = apb_req.psel && apb_req.penable && apb_req.pwrite
                      && apb_req.paddr == ADDR_CMD && apb_rsp.pready;

    a_stream: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> exp_avail && out_data == exp_head)
        else mismatch("stream result", 64'($sampled(exp_head)), 64'($sampled(out_data)));

    a_first_latency: assert property (@(posedge clk) disable iff (rst)
        cmd_done && lat_en |-> ##7 !out_valid ##1 out_valid)
        else give_up("first result did not appear 8 cycles after the CMD write");

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic err;
        int ea;
        int n;
        seed = 32'haf2c67c6;
        issued = 0;
        popped = 0;
        lat_en = 1'b0;
        test_name = "reset";
        rst = 1'b1;
        apb_req = '0;
        out_ready = 1'b0;
        update_head();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        assert (apb_rsp.pready && !apb_rsp.pslverr && !out_valid)
            else give_up("outputs not idle after reset");

        test_name = "exact_add";
        out_ready = 1'b1;
        lat_en = 1'b1;
        run_op(32'h3fc00000, 32'h40100000, 1'b0);
        lat_en = 1'b0;
        run_op(32'h3f800000, 32'h3f800000, 1'b0);
        run_op(32'h3f000000, 32'h3e800000, 1'b0);
        // Exponent zero with a nonzero fraction still counts as zero
        run_op(32'h00400000, 32'h40000000, 1'b0);
        wait_drain();

        test_name = "subtract";
        run_op(32'h3f800000, 32'h40400000, 1'b1);
        run_op(32'h40200000, 32'h40200000, 1'b1);
        run_op(32'h00800000, 32'h00800001, 1'b1);
        wait_drain();
        read_check(ADDR_STATUS, 32'h1, 32'h3, "sticky underflow set");
        write_reg(ADDR_STATUS, 32'h1);
        read_check(ADDR_STATUS, 32'h0, 32'h3, "sticky underflow cleared");

        test_name = "random";
        for (int i = 0; i < 150; i++) begin
            a = $random(seed);
            b = $random(seed);
            ea = 60 + ($unsigned($random(seed)) % 120);
            a[30:23] = 8'(ea);
            if (i % 4 != 0) begin
                b[30:23] = 8'(ea + ($random(seed) % 4));
            end else begin
                b[30:23] = 8'(60 + ($unsigned($random(seed)) % 120));
            end
            run_op(a, b, 1'($random(seed)));
        end
        // b is exactly half an ulp of a
        for (int i = 0; i < 12; i++) begin
            a = $random(seed);
            ea = 80 + ($unsigned($random(seed)) % 60);
            a[31] = 1'b0;
            a[30:23] = 8'(ea);
            b = {1'b0, 8'(ea - 24), 23'd0};
            run_op(a, b, 1'b0);
        end
        run_op(32'h3f800000, 32'h33800000, 1'b0);
        run_op(32'h3f800001, 32'h33800000, 1'b0);
        wait_drain();

        test_name = "overflow";
        run_op(32'h7f7fffff, 32'h7f7fffff, 1'b0);
        wait_drain();
        read_check(ADDR_STATUS, 32'h2, 32'h3, "sticky overflow set");
        write_reg(ADDR_STATUS, 32'h2);
        read_check(ADDR_STATUS, 32'h0, 32'h3, "sticky overflow cleared");

        test_name = "backpressure";
        out_ready = 1'b0;
        for (int i = 0; i < 8; i++) begin
            run_op(32'h3f800000 + i, 32'h40000000, 1'b0);
        end
        repeat (PIPE_LATENCY + 1) @(posedge clk);
        read_check(ADDR_STATUS, 32'h80, 32'hf0, "occupancy with eight results held");
        fork
            run_op(32'h40400000, 32'h3f800000, 1'b1);
            begin
                n = 0;
                while (!(apb_req.penable && apb_req.paddr == ADDR_CMD)) begin
                    @(posedge clk);
                    #2;
                    n++;
                    if (n > 50) give_up("timeout waiting for the ninth CMD write");
                end
                assert (!apb_rsp.pready) else mismatch("pready on ninth CMD", 64'd0, 64'd1);
                repeat (3) @(posedge clk);
                #1;
                out_ready = 1'b1;
            end
        join
        wait_drain();
        read_check(ADDR_STATUS, 32'h0, 32'hf0, "occupancy after drain");

        test_name = "registers";
        write_reg(ADDR_OPA, 32'h12345678);
        write_reg(ADDR_OPB, 32'h9abcdef0);
        read_check(ADDR_OPA, 32'h12345678, '1, "OPA readback");
        read_check(ADDR_OPB, 32'h9abcdef0, '1, "OPB readback");
        read_check(ADDR_CMD, 32'h1, '1, "CMD readback");
        apb_xfer(1'b1, 4'h9, 32'h1, rd, err);
        assert (err) else mismatch("pslverr on unmapped write", 64'd1, 64'(err));
        apb_xfer(1'b1, 4'h1, 32'hffffffff, rd, err);
        assert (err) else mismatch("pslverr on unmapped write", 64'd1, 64'(err));
        apb_xfer(1'b0, 4'h2, '0, rd, err);
        assert (err) else mismatch("pslverr on unmapped read", 64'd1, 64'(err));
        read_check(ADDR_OPA, 32'h12345678, '1, "OPA after unmapped write");
        repeat (PIPE_LATENCY + 2) @(posedge clk);
        assert (popped == issued && !out_valid)
            else mismatch("results after unmapped access", 64'(issued), 64'(popped));

        if (exp_q.size() == 0 && popped == issued) begin
            $display("TEST PASS");
            $finish;
        end else begin
            give_up("expected results left over at the end");
        end
    end

endmodule

// File: build.f
rtl/fp_accel_pkg.sv
rtl/leading_one_detector.sv
rtl/result_rounder.sv
rtl/fp_add_pipe.sv
rtl/apb_op_regs.sv
rtl/result_fifo.sv
rtl/fp_accel_top.sv
tb/tb_fp_accel.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fp_accel \
    -Mdir obj_dir \
    -f build.f

./obj_dir/Vtb_fp_accel
